// File: PipelineCore.f
common/CorePkg.sv
src/CoreControl.sv
src/ProgramCounter.sv
decode/InstructionDecode.sv
execute/ExecuteUnit.sv
src/WritebackUnit.sv
src/PipelineCore.sv
test/PipelineCore_assert.sv
test/PipelineCoreTb.sv

// File: Makefile
SOURCES := $(shell cat PipelineCore.f)
BIN := obj_dir/VPipelineCoreTb

.PHONY: run clean

run: $(BIN)
	./$(BIN) +verilator+error+limit+10 > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TESTBENCH FAILED" sim.log
	grep -q "TESTBENCH PASSED" sim.log

$(BIN): $(SOURCES) PipelineCore.f
	verilator --binary --timing --assert -f PipelineCore.f \
		--top-module PipelineCoreTb -o VPipelineCoreTb

clean:
	rm -rf obj_dir sim.log

// File: test/PipelineCoreTb.sv
`timescale 1ns/1ps

module PipelineCoreTb;

	localparam int MEM_WORDS = 128;
	localparam int RESET_CYCLES = 4;
	// Program ends within about 60 cycles, register reads add about 25
	localparam int TIMEOUT_CYCLES = 400;
	localparam logic [31:0] DONE_ADDRESS = 32'h44;

	// Flag order follows ManagementCmd: halt, run, setPc, jumpPc, readReg
	localparam logic [4:0] HALT_FLAG = 5'b10000;
	localparam logic [4:0] RUN_FLAG = 5'b01000;
	localparam logic [4:0] SET_FLAG = 5'b00100;
	localparam logic [4:0] JUMP_FLAG = 5'b00010;
	localparam logic [4:0] READ_FLAG = 5'b00001;

	logic clk = 1'b0;
	logic rst = 1'b1;
	CorePkg::ManagementCmd management = '0;
	logic [4:0] managementRegIndex = 5'd0;
	logic [31:0] instruction;
	logic [31:0] fetchProgramCounter;
	logic [31:0] executeProgramCounter;
	logic [31:0] managementReadData;
	CorePkg::CoreState state;

	logic [31:0] imem [MEM_WORDS];
	logic [31:0] refRegs [32];
	logic [31:0] seed = 32'h1a1a_0408;
	logic [31:0] placeAddr = 32'h0;
	int cycleCount = 0;

	PipelineCore PipelineCore_i (
		.clk(clk),
		.rst(rst),
		.management(management),
		.managementRegIndex(managementRegIndex),
		.managementReadData(managementReadData),
		.fetchProgramCounter(fetchProgramCounter),
		.instruction(instruction),
		.state(state),
		.executeProgramCounter(executeProgramCounter)
	);

	// Instruction memory answers in the same cycle
	assign instruction = imem[fetchProgramCounter[8:2]];

	always #5 clk = ~clk;

	function automatic logic [31:0] nextRandom(input logic [31:0] current);
		return current * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] addiWord(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	task automatic failRun(input string message);
		$display("ERROR %0t: %s", $time, message);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic storeWord(input logic [31:0] word);
		imem[placeAddr[8:2]] = word;
		placeAddr = placeAddr + 32'd4;
	endtask

	// The emit tasks place a word and apply its effect to the register model
	task automatic emitAddi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		storeWord(addiWord(rd, rs1, imm));
		refRegs[rd] = refRegs[rs1] + {{20{imm[11]}}, imm};
	endtask

	task automatic emitAlu(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
		input logic subtract);
		storeWord({1'b0, subtract, 5'b0, rs2, rs1, 3'b000, rd, 7'b0110011});
		refRegs[rd] = subtract ? refRegs[rs1] - refRegs[rs2] : refRegs[rs1] + refRegs[rs2];
	endtask

	task automatic emitLui(input logic [4:0] rd, input logic [19:0] imm);
		storeWord({imm, rd, 7'b0110111});
		refRegs[rd] = {imm, 12'b0};
	endtask

	task automatic emitBranch(input logic [2:0] funct3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] offset);
		storeWord({offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11],
			7'b1100011});
	endtask

	task automatic emitJal(input logic [4:0] rd, input logic [20:0] offset);
		if (rd != 5'd0) begin
			refRegs[rd] = placeAddr + 32'd4;
		end
		storeWord({offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111});
	endtask

	task automatic loadProgram();
		int i;
		for (i = 0; i < MEM_WORDS; i++) begin
			// Unused words are ADDI x0 carrying their own word index
			imem[i[6:0]] = addiWord(5'd0, 5'd0, 12'(i));
		end
		for (i = 0; i < 32; i++) begin
			refRegs[i[4:0]] = '0;
		end
		seed = nextRandom(seed);
		emitAddi(5'd1, 5'd0, seed[27:16]);
		seed = nextRandom(seed);
		emitAddi(5'd2, 5'd0, seed[27:16]);
		seed = nextRandom(seed);
		emitAddi(5'd6, 5'd0, seed[27:16]);
		emitAlu(5'd3, 5'd1, 5'd2, 1'b0);
		emitAlu(5'd4, 5'd1, 5'd2, 1'b1);
		emitLui(5'd5, 20'h12345);
		seed = nextRandom(seed);
		emitAddi(5'd5, 5'd5, seed[27:16]);
		// BNE on equal operands falls through to the BEQ
		emitBranch(3'b001, 5'd1, 5'd1, 13'd8);
		emitBranch(3'b000, 5'd0, 5'd0, 13'd12);
		// Squashed behind the BEQ, then skipped
		storeWord(addiWord(5'd6, 5'd0, 12'd7));
		storeWord(addiWord(5'd6, 5'd0, 12'd8));
		emitJal(5'd8, 21'd16);
		storeWord(addiWord(5'd6, 5'd0, 12'd9));
		placeAddr = 32'h3C;
		storeWord(32'hffff_ffff);
		// First word after the trap return
		emitAddi(5'd9, 5'd8, 12'd1);
		// Self loop marks the end
		emitJal(5'd0, 21'd0);
		placeAddr = CorePkg::TRAP_VECTOR;
		storeWord(32'h3020_0073);
	endtask

	// One-cycle strobe, entered and left on a falling edge
	task automatic strobe(input logic [4:0] flags, input logic [31:0] data);
		management = {flags, data};
		@(negedge clk);
		management = '0;
	endtask

	task automatic checkRegister(input logic [4:0] index);
		managementRegIndex = index;
		strobe(READ_FLAG, 32'h0);
		assert (managementReadData === refRegs[index])
			else failRun($sformatf("x%0d reads %h, model expects %h", index,
				managementReadData, refRegs[index]));
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the program never reached its end", cycleCount);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end else if (PipelineCore_i.PipelineCore_assert_i.failCount != 0) begin
			$display("A bound assertion on the core failed at %0t", $time);
			$display("TESTBENCH FAILED");
			$fatal(1, "assertion failure");
		end
	end

	initial begin
		int i;
		loadProgram();
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		repeat (3) @(negedge clk);
		assert (state == CorePkg::HALT && fetchProgramCounter == CorePkg::RESET_VECTOR)
			else failRun("core left HALT or moved its fetch PC without a strobe");
		checkRegister(5'd0);
		strobe(JUMP_FLAG, 32'h20);
		strobe(SET_FLAG, 32'h40);
		assert (fetchProgramCounter == 32'h40)
			else failRun($sformatf("fetch PC %h after setPc", fetchProgramCounter));
		strobe(SET_FLAG, CorePkg::RESET_VECTOR);
		strobe(RUN_FLAG, 32'h0);
		while (fetchProgramCounter != DONE_ADDRESS) @(negedge clk);
		strobe(HALT_FLAG, 32'h0);
		while (state != CorePkg::HALT) @(negedge clk);
		@(negedge clk);
		for (i = 1; i < 10; i++) begin
			// x7 is never written
			if (i != 7) begin
				checkRegister(5'(i));
			end
		end
		// Execute PC still holds the self loop word
		strobe(JUMP_FLAG, 32'h20);
		assert (fetchProgramCounter == DONE_ADDRESS + 32'h20)
			else failRun($sformatf("fetch PC %h after jumpPc", fetchProgramCounter));
		if (PipelineCore_i.PipelineCore_assert_i.failCount == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("A bound assertion on the core failed");
			$display("TESTBENCH FAILED");
			$fatal(1, "assertion failure");
		end
	end

endmodule

// File: test/PipelineCore_assert.sv
`timescale 1ns/1ps

module PipelineCore_assert (
	input wire logic clk,
	input wire logic rst,
	input wire CorePkg::ManagementCmd management,
	input wire logic [4:0] managementRegIndex,
	input wire logic [31:0] managementReadData,
	input wire logic [31:0] fetchProgramCounter,
	input wire logic [31:0] executeProgramCounter,
	input wire CorePkg::CoreState state,
	input wire logic stepPipe,
	input wire logic redirect,
	input wire logic inTrap,
	input wire logic isRet,
	input wire CorePkg::ExecResult result
);

	int failCount = 0;
	logic [31:0] returnAddress;

	task automatic recordFailure(input string what);
		$error("%s", what);
		failCount++;
	endtask

	// Fetch is already one word past the trapping op when it executes
	always_ff @(posedge clk) begin
		if (rst) begin
			returnAddress <= '0;
		end else if (inTrap) begin
			returnAddress <= fetchProgramCounter;
		end
	end

	resetState: assert property (@(posedge clk) rst |=> state == CorePkg::HALT
		&& fetchProgramCounter == CorePkg::RESET_VECTOR && executeProgramCounter == '0
		&& managementReadData == '0) else recordFailure("reset values wrong");

	sequentialFetch: assert property (@(posedge clk) disable iff (rst)
		stepPipe && !redirect |=> fetchProgramCounter == $past(fetchProgramCounter) + 32'd4)
		else recordFailure("fetch PC did not advance by 4");

	haltedHold: assert property (@(posedge clk) disable iff (rst)
		state == CorePkg::HALT && !redirect && !management.setPc && !management.jumpPc
		|=> fetchProgramCounter == $past(fetchProgramCounter))
		else recordFailure("fetch PC moved while halted");

	setPcLoads: assert property (@(posedge clk) disable iff (rst)
		state == CorePkg::HALT && !redirect && management.setPc
		|=> fetchProgramCounter == $past(management.data))
		else recordFailure("setPc did not load the fetch PC");

	jumpPcLoads: assert property (@(posedge clk) disable iff (rst)
		state == CorePkg::HALT && !redirect && !management.setPc && management.jumpPc
		|=> fetchProgramCounter == $past(executeProgramCounter + management.data))
		else recordFailure("jumpPc did not move the fetch PC");

	takenJump: assert property (@(posedge clk) disable iff (rst)
		result.jumpEnable |=> fetchProgramCounter == $past(result.jumpTarget))
		else recordFailure("taken jump or branch missed its target");

	trapEntry: assert property (@(posedge clk) disable iff (rst)
		inTrap |=> fetchProgramCounter == CorePkg::TRAP_VECTOR)
		else recordFailure("illegal word did not reach the trap vector");

	trapReturn: assert property (@(posedge clk) disable iff (rst)
		isRet |=> fetchProgramCounter == $past(returnAddress))
		else recordFailure("MRET returned to the wrong address");

	zeroRead: assert property (@(posedge clk) disable iff (rst)
		management.readReg && managementRegIndex == 5'd0 |=> managementReadData == '0)
		else recordFailure("x0 read was not zero");

endmodule

bind PipelineCore PipelineCore_assert PipelineCore_assert_i (
	.clk(clk),
	.rst(rst),
	.management(management),
	.managementRegIndex(managementRegIndex),
	.managementReadData(managementReadData),
	.fetchProgramCounter(fetchProgramCounter),
	.executeProgramCounter(executeProgramCounter),
	.state(state),
	.stepPipe(stepPipe),
	.redirect(redirect),
	.inTrap(inTrap),
	.isRet(isRet),
	.result(result)
);

// File: src/PipelineCore.sv
`timescale 1ns/1ps
`default_nettype none

module PipelineCore (
	input wire logic clk,
	input wire logic rst,

	// Management port
	input CorePkg::ManagementCmd management,
	input wire logic [CorePkg::REG_INDEX_WIDTH-1:0] managementRegIndex,
	output logic [CorePkg::XLEN-1:0] managementReadData,

	// Instruction fetch
	output logic [CorePkg::XLEN-1:0] fetchProgramCounter,
	input wire logic [CorePkg::XLEN-1:0] instruction,

	output CorePkg::CoreState state,
	output logic [CorePkg::XLEN-1:0] executeProgramCounter
);

	logic stepPipe;
	logic inTrap;
	logic isRet;
	logic redirect;
	logic [CorePkg::XLEN-1:0] rs1Value;
	logic [CorePkg::XLEN-1:0] rs2Value;
	CorePkg::DecodedOp decoded;
	CorePkg::ExecResult result;

	CoreControl CoreControl_i (
		.clk(clk),
		.rst(rst),
		.management(management),
		.state(state),
		.stepPipe(stepPipe)
	);

	ProgramCounter ProgramCounter_i (
		.clk(clk),
		.rst(rst),
		.state(state),
		.stepPipe(stepPipe),
		.management(management),
		.inTrap(inTrap),
		.isRet(isRet),
		.result(result),
		.fetchProgramCounter(fetchProgramCounter),
		.executeProgramCounter(executeProgramCounter)
	);

	InstructionDecode InstructionDecode_i (
		.clk(clk),
		.rst(rst),
		.stepPipe(stepPipe),
		.flush(redirect),
		.instruction(instruction),
		.fetchProgramCounter(fetchProgramCounter),
		.decoded(decoded)
	);

	ExecuteUnit ExecuteUnit_i (
		.decoded(decoded),
		.rs1Value(rs1Value),
		.rs2Value(rs2Value),
		.result(result),
		.inTrap(inTrap),
		.isRet(isRet),
		.redirect(redirect)
	);

	WritebackUnit WritebackUnit_i (
		.clk(clk),
		.rst(rst),
		.decoded(decoded),
		.result(result),
		.managementRegIndex(managementRegIndex),
		.readReg(management.readReg),
		.rs1Value(rs1Value),
		.rs2Value(rs2Value),
		.managementReadData(managementReadData)
	);

endmodule

// File: src/WritebackUnit.sv
`timescale 1ns/1ps
`default_nettype none

module WritebackUnit (
	input wire logic clk,
	input wire logic rst,
	input CorePkg::DecodedOp decoded,
	input CorePkg::ExecResult result,
	input wire logic [CorePkg::REG_INDEX_WIDTH-1:0] managementRegIndex,
	input wire logic readReg,
	output logic [CorePkg::XLEN-1:0] rs1Value,
	output logic [CorePkg::XLEN-1:0] rs2Value,
	output logic [CorePkg::XLEN-1:0] managementReadData
);

	logic [CorePkg::XLEN-1:0] registers [CorePkg::REG_COUNT];

	// x0 is never written
	always_ff @(posedge clk) begin
		if (result.writeEnable && result.rd != '0) begin
			registers[result.rd] <= result.value;
		end
	end

	// Operand reads see writes from the previous edge
	assign rs1Value = (decoded.rs1 == '0) ? '0 : registers[decoded.rs1];
	assign rs2Value = (decoded.rs2 == '0) ? '0 : registers[decoded.rs2];

	always_ff @(posedge clk) begin
		if (rst) begin
			managementReadData <= '0;
		end else if (readReg) begin
			if (managementRegIndex == '0) begin
				managementReadData <= '0;
			end else begin
				managementReadData <= registers[managementRegIndex];
			end
		end
	end

endmodule

// File: execute/ExecuteUnit.sv
`timescale 1ns/1ps
`default_nettype none

module ExecuteUnit (
	input CorePkg::DecodedOp decoded,
	input wire logic [CorePkg::XLEN-1:0] rs1Value,
	input wire logic [CorePkg::XLEN-1:0] rs2Value,
	output CorePkg::ExecResult result,
	output logic inTrap,
	output logic isRet,
	output logic redirect
);

	logic operandsEqual;
	logic [CorePkg::XLEN-1:0] linkValue;

	assign operandsEqual = (rs1Value == rs2Value);
	assign linkValue = decoded.pc + 32'd4;

	always_comb begin
		result.writeEnable = 1'b0;
		result.rd = decoded.rd;
		result.value = '0;
		result.jumpEnable = 1'b0;
		// JAL and branches share pc-relative targets
		result.jumpTarget = decoded.pc + decoded.imm;
		inTrap = 1'b0;
		isRet = 1'b0;
		if (decoded.valid) begin
			case (decoded.op)
				CorePkg::ADDI: begin
					result.writeEnable = 1'b1;
					result.value = rs1Value + decoded.imm;
				end
				CorePkg::ADD: begin
					result.writeEnable = 1'b1;
					result.value = rs1Value + rs2Value;
				end
				CorePkg::SUB: begin
					result.writeEnable = 1'b1;
					result.value = rs1Value - rs2Value;
				end
				CorePkg::LUI: begin
					result.writeEnable = 1'b1;
					result.value = decoded.imm;
				end
				CorePkg::JAL: begin
					result.writeEnable = 1'b1;
					result.value = linkValue;
					result.jumpEnable = 1'b1;
				end
				CorePkg::BEQ: result.jumpEnable = operandsEqual;
				CorePkg::BNE: result.jumpEnable = !operandsEqual;
				CorePkg::MRET: isRet = 1'b1;
				default: inTrap = 1'b1;
			endcase
		end
	end

	// Squash the word fetched behind any control transfer
	assign redirect = result.jumpEnable || inTrap || isRet;

endmodule

// File: decode/InstructionDecode.sv
`timescale 1ns/1ps
`default_nettype none

module InstructionDecode (
	input wire logic clk,
	input wire logic rst,
	input wire logic stepPipe,
	input wire logic flush,
	input wire logic [CorePkg::XLEN-1:0] instruction,
	input wire logic [CorePkg::XLEN-1:0] fetchProgramCounter,
	output CorePkg::DecodedOp decoded
);

	logic stageValid;
	logic [CorePkg::XLEN-1:0] stageInstruction;
	logic [CorePkg::XLEN-1:0] stagePc;

	logic [CorePkg::XLEN-1:0] immI;
	logic [CorePkg::XLEN-1:0] immU;
	logic [CorePkg::XLEN-1:0] immJ;
	logic [CorePkg::XLEN-1:0] immB;
	logic [2:0] funct3;
	logic [6:0] funct7;

	// Bubble on squash or while not stepping
	always_ff @(posedge clk) begin
		if (rst) begin
			stageValid <= 1'b0;
		end else begin
			stageValid <= stepPipe && !flush;
		end
	end

	always_ff @(posedge clk) begin
		if (stepPipe) begin
			stageInstruction <= instruction;
			stagePc <= fetchProgramCounter;
		end
	end

	assign funct3 = stageInstruction[14:12];
	assign funct7 = stageInstruction[31:25];

	assign immI = {{20{stageInstruction[31]}}, stageInstruction[31:20]};
	assign immU = {stageInstruction[31:12], 12'b0};
	assign immJ = {{12{stageInstruction[31]}}, stageInstruction[19:12], stageInstruction[20],
		stageInstruction[30:21], 1'b0};
	assign immB = {{20{stageInstruction[31]}}, stageInstruction[7], stageInstruction[30:25],
		stageInstruction[11:8], 1'b0};

	always_comb begin
		decoded.valid = stageValid;
		decoded.rd = stageInstruction[11:7];
		decoded.rs1 = stageInstruction[19:15];
		decoded.rs2 = stageInstruction[24:20];
		decoded.pc = stagePc;
		decoded.op = CorePkg::ILLEGAL;
		decoded.imm = immI;
		case (CorePkg::RvOpcode'(stageInstruction[6:0]))
			CorePkg::OPC_OP_IMM: begin
				if (funct3 == 3'b000) decoded.op = CorePkg::ADDI;
			end
			CorePkg::OPC_OP: begin
				if (funct3 == 3'b000 && funct7 == 7'b0000000) decoded.op = CorePkg::ADD;
				else if (funct3 == 3'b000 && funct7 == 7'b0100000) decoded.op = CorePkg::SUB;
			end
			CorePkg::OPC_LUI: begin
				decoded.op = CorePkg::LUI;
				decoded.imm = immU;
			end
			CorePkg::OPC_JAL: begin
				decoded.op = CorePkg::JAL;
				decoded.imm = immJ;
			end
			CorePkg::OPC_BRANCH: begin
				decoded.imm = immB;
				if (funct3 == 3'b000) decoded.op = CorePkg::BEQ;
				else if (funct3 == 3'b001) decoded.op = CorePkg::BNE;
			end
			CorePkg::OPC_SYSTEM: begin
				if (stageInstruction == CorePkg::MRET_WORD) decoded.op = CorePkg::MRET;
			end
			default: decoded.op = CorePkg::ILLEGAL;
		endcase
	end

endmodule

// File: src/ProgramCounter.sv
`timescale 1ns/1ps
`default_nettype none

module ProgramCounter (
	input wire logic clk,
	input wire logic rst,

	// Pipe control
	input CorePkg::CoreState state,
	input wire logic stepPipe,
	input CorePkg::ManagementCmd management,

	// Redirects from execute
	input wire logic inTrap,
	input wire logic isRet,
	input CorePkg::ExecResult result,

	output logic [CorePkg::XLEN-1:0] fetchProgramCounter,
	output logic [CorePkg::XLEN-1:0] executeProgramCounter
);

	logic [CorePkg::XLEN-1:0] nextFetchProgramCounter;
	logic [CorePkg::XLEN-1:0] trapReturnAddress;

	// Redirects win over sequential fetch and over halted commands
	// A valid op only sits in execute right after a stepping cycle, so an op
	// in flight when halt lands still gets its redirect applied
	always_comb begin
		nextFetchProgramCounter = fetchProgramCounter;
		if (inTrap) begin
			nextFetchProgramCounter = CorePkg::TRAP_VECTOR;
		end else if (isRet) begin
			nextFetchProgramCounter = trapReturnAddress;
		end else if (result.jumpEnable) begin
			nextFetchProgramCounter = result.jumpTarget;
		end else if (stepPipe) begin
			nextFetchProgramCounter = fetchProgramCounter + 32'd4;
		end else if (state == CorePkg::HALT) begin
			if (management.setPc) begin
				nextFetchProgramCounter = management.data;
			end else if (management.jumpPc) begin
				nextFetchProgramCounter = executeProgramCounter + management.data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fetchProgramCounter <= CorePkg::RESET_VECTOR;
			executeProgramCounter <= '0;
			trapReturnAddress <= '0;
		end else begin
			fetchProgramCounter <= nextFetchProgramCounter;
			// Execute PC follows the word handed to the stage register
			if (stepPipe) begin
				executeProgramCounter <= fetchProgramCounter;
			end
			// Return to the word after the trapping one
			if (inTrap) begin
				trapReturnAddress <= executeProgramCounter + 32'd4;
			end
		end
	end

endmodule

// File: src/CoreControl.sv
`timescale 1ns/1ps
`default_nettype none

module CoreControl (
	input wire logic clk,
	input wire logic rst,
	input CorePkg::ManagementCmd management,
	output CorePkg::CoreState state,
	output logic stepPipe
);

	CorePkg::CoreState nextState;

	always_comb begin
		nextState = state;
		case (state)
			CorePkg::HALT: begin
				if (management.run) begin
					nextState = CorePkg::EXECUTE;
				end
			end
			CorePkg::EXECUTE: begin
				if (management.halt) begin
					nextState = CorePkg::HALT;
				end
			end
			default: nextState = CorePkg::HALT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= CorePkg::HALT;
		end else begin
			state <= nextState;
		end
	end

	// Pipeline only advances while executing
	assign stepPipe = (state == CorePkg::EXECUTE);

endmodule

// File: common/CorePkg.sv
package CorePkg;

	localparam int XLEN = 32;
	localparam int REG_COUNT = 32;
	localparam int REG_INDEX_WIDTH = $clog2(REG_COUNT);

	localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0000;
	localparam logic [XLEN-1:0] TRAP_VECTOR = 32'h0000_0100;

	// Full encoding of mret, matched as a whole word
	localparam logic [XLEN-1:0] MRET_WORD = 32'h3020_0073;

	typedef enum logic {
		HALT = 1'b0,
		EXECUTE = 1'b1
	} CoreState;

	// Major opcode field, instruction bits 6:0
	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011,
		OPC_OP = 7'b0110011,
		OPC_LUI = 7'b0110111,
		OPC_JAL = 7'b1101111,
		OPC_BRANCH = 7'b1100011,
		OPC_SYSTEM = 7'b1110011
	} RvOpcode;

	typedef enum logic [3:0] {
		ADDI,
		ADD,
		SUB,
		LUI,
		JAL,
		BEQ,
		BNE,
		MRET,
		ILLEGAL
	} OpKind;

	typedef struct packed {
		logic valid;
		OpKind op;
		logic [REG_INDEX_WIDTH-1:0] rd;
		logic [REG_INDEX_WIDTH-1:0] rs1;
		logic [REG_INDEX_WIDTH-1:0] rs2;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] pc;
	} DecodedOp;

	typedef struct packed {
		logic writeEnable;
		logic [REG_INDEX_WIDTH-1:0] rd;
		logic [XLEN-1:0] value;
		logic jumpEnable;
		logic [XLEN-1:0] jumpTarget;
	} ExecResult;

	typedef struct packed {
		logic halt;
		logic run;
		logic setPc;
		logic jumpPc;
		logic readReg;
		logic [XLEN-1:0] data;
	} ManagementCmd;

endpackage
